// File: vga_settings.svh
`ifndef VGA_SETTINGS_SVH
`define VGA_SETTINGS_SVH

// ============================================================
// counter widths
// ============================================================
`define VGA_COLBITS 10
`define VGA_ROWBITS 10

// ============================================================
// cell grid and framebuffer
// ============================================================
`define VGA_CELL_SHIFT 3
`define VGA_CELLS_PER_ROW 80
`define VGA_FB_ADDRBITS 13
`define VGA_FB_DEPTH 4800
`define VGA_RGBBITS 12

`endif

// File: vga_pkg.sv
package vga_pkg;

    // ============================================================
    // video modes
    // ============================================================
    typedef enum logic {
        MODE_640X480 = 1'b0,    // 800x525 total.
        MODE_640X400 = 1'b1     // 800x449 total.
    } vga_mode_e;

    // ============================================================
    // framebuffer port owner
    // ============================================================
    // scanout reads have priority over host writes.
    typedef enum logic {
        OWNER_SCAN = 1'b0,
        OWNER_HOST = 1'b1
    } fb_owner_e;

endpackage

// File: vga_mode_generator.sv
`timescale 1ns/1ps
`include "vga_settings.svh"

module vga_mode_generator import vga_pkg::*; (
    input  vga_mode_e                mode,
    output logic [`VGA_COLBITS-1:0]  last_visible_col,
    output logic [`VGA_COLBITS-1:0]  h_pulse_start,
    output logic [`VGA_COLBITS-1:0]  h_pulse_end,
    output logic [`VGA_COLBITS-1:0]  last_col,
    output logic [`VGA_ROWBITS-1:0]  last_visible_row,
    output logic [`VGA_ROWBITS-1:0]  v_pulse_start,
    output logic [`VGA_ROWBITS-1:0]  v_pulse_end,
    output logic [`VGA_ROWBITS-1:0]  last_row,
    output logic                     h_pulse_polarity,
    output logic                     v_pulse_polarity
);

    // horizontal timing is shared by both modes.
    localparam logic [`VGA_COLBITS-1:0] H_VISIBLE = 10'd640;
    localparam logic [`VGA_COLBITS-1:0] H_FRONT   = 10'd16;
    localparam logic [`VGA_COLBITS-1:0] H_PULSE   = 10'd96;
    localparam logic [`VGA_COLBITS-1:0] H_BACK    = 10'd48;

    localparam logic [`VGA_ROWBITS-1:0] V0_VISIBLE = 10'd480;
    localparam logic [`VGA_ROWBITS-1:0] V0_FRONT   = 10'd10;
    localparam logic [`VGA_ROWBITS-1:0] V0_PULSE   = 10'd2;
    localparam logic [`VGA_ROWBITS-1:0] V0_BACK    = 10'd33;

    localparam logic [`VGA_ROWBITS-1:0] V1_VISIBLE = 10'd400;
    localparam logic [`VGA_ROWBITS-1:0] V1_FRONT   = 10'd1;
    localparam logic [`VGA_ROWBITS-1:0] V1_PULSE   = 10'd3;
    localparam logic [`VGA_ROWBITS-1:0] V1_BACK    = 10'd45;

    // pulse limits are inclusive on both ends.
    assign last_visible_col = H_VISIBLE - 1'b1;
    assign h_pulse_start    = H_VISIBLE + H_FRONT;
    assign h_pulse_end      = H_VISIBLE + H_FRONT + H_PULSE - 1'b1;
    assign last_col         = H_VISIBLE + H_FRONT + H_PULSE + H_BACK - 1'b1;
    assign h_pulse_polarity = 1'b0;          // negative in both modes.

    always_comb begin
        unique case (mode)
            MODE_640X480: begin
                last_visible_row = V0_VISIBLE - 1'b1;
                v_pulse_start    = V0_VISIBLE + V0_FRONT;
                v_pulse_end      = V0_VISIBLE + V0_FRONT + V0_PULSE - 1'b1;
                last_row         = V0_VISIBLE + V0_FRONT + V0_PULSE + V0_BACK - 1'b1;
                v_pulse_polarity = 1'b0;
            end
            MODE_640X400: begin
                last_visible_row = V1_VISIBLE - 1'b1;
                v_pulse_start    = V1_VISIBLE + V1_FRONT;
                v_pulse_end      = V1_VISIBLE + V1_FRONT + V1_PULSE - 1'b1;
                last_row         = V1_VISIBLE + V1_FRONT + V1_PULSE + V1_BACK - 1'b1;
                v_pulse_polarity = 1'b1;
            end
        endcase
    end

endmodule

// File: vga_timing.sv
`timescale 1ns/1ps
`include "vga_settings.svh"

module vga_timing import vga_pkg::*; (
    input  logic                     clk,
    input  logic                     arst_n,
    input  vga_mode_e                mode_req,
    output logic [`VGA_COLBITS-1:0]  col,
    output logic [`VGA_ROWBITS-1:0]  row,
    output logic                     hsync,
    output logic                     vsync,
    output logic                     visible,
    output logic                     frame_start
);

    vga_mode_e                  mode_q;
    logic [`VGA_COLBITS-1:0]    h_cnt;
    logic [`VGA_ROWBITS-1:0]    v_cnt;
    logic [`VGA_COLBITS-1:0]    last_visible_col;
    logic [`VGA_COLBITS-1:0]    h_pulse_start;
    logic [`VGA_COLBITS-1:0]    h_pulse_end;
    logic [`VGA_COLBITS-1:0]    last_col;
    logic [`VGA_ROWBITS-1:0]    last_visible_row;
    logic [`VGA_ROWBITS-1:0]    v_pulse_start;
    logic [`VGA_ROWBITS-1:0]    v_pulse_end;
    logic [`VGA_ROWBITS-1:0]    last_row;
    logic                       h_pulse_polarity;
    logic                       v_pulse_polarity;
    logic                       line_end;
    logic                       frame_end;
    logic                       h_active;
    logic                       v_active;

    vga_mode_generator u_mode_gen (
        .mode             (mode_q),
        .last_visible_col (last_visible_col),
        .h_pulse_start    (h_pulse_start),
        .h_pulse_end      (h_pulse_end),
        .last_col         (last_col),
        .last_visible_row (last_visible_row),
        .v_pulse_start    (v_pulse_start),
        .v_pulse_end      (v_pulse_end),
        .last_row         (last_row),
        .h_pulse_polarity (h_pulse_polarity),
        .v_pulse_polarity (v_pulse_polarity)
    );

    assign line_end  = (h_cnt == last_col);
    assign frame_end = line_end && (v_cnt == last_row);
    assign h_active  = (h_cnt >= h_pulse_start) && (h_cnt <= h_pulse_end);
    assign v_active  = (v_cnt >= v_pulse_start) && (v_cnt <= v_pulse_end);

    // ============================================================
    // position counters
    // ============================================================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            h_cnt  <= '0;
            v_cnt  <= '0;
            mode_q <= MODE_640X480;
        end else begin
            h_cnt <= line_end ? '0 : h_cnt + 1'b1;
            if (frame_end) begin
                v_cnt  <= '0;
                mode_q <= mode_req;          // new mode starts with the next frame.
            end else if (line_end) begin
                v_cnt <= v_cnt + 1'b1;
            end
        end
    end

    // ============================================================
    // registered outputs, all aligned to col and row
    // ============================================================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            col         <= '0;
            row         <= '0;
            hsync       <= 1'b1;
            vsync       <= 1'b1;
            visible     <= 1'b0;
            frame_start <= 1'b0;
        end else begin
            col         <= h_cnt;
            row         <= v_cnt;
            hsync       <= h_active ? h_pulse_polarity : ~h_pulse_polarity;
            vsync       <= v_active ? v_pulse_polarity : ~v_pulse_polarity;
            visible     <= (h_cnt <= last_visible_col) && (v_cnt <= last_visible_row);
            frame_start <= frame_end;        // high while the counters sit at (0,0).
        end
    end

endmodule

// File: vga_scanout.sv
`timescale 1ns/1ps
`include "vga_settings.svh"

module vga_scanout (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic [`VGA_COLBITS-1:0]      col,
    input  logic [`VGA_ROWBITS-1:0]      row,
    input  logic                         hsync,
    input  logic                         vsync,
    input  logic                         visible,
    input  logic [`VGA_RGBBITS-1:0]      ram_rdata,
    output logic                         scan_req,
    output logic [`VGA_FB_ADDRBITS-1:0]  scan_addr,
    output logic                         vga_hsync,
    output logic                         vga_vsync,
    output logic [`VGA_RGBBITS-1:0]      vga_rgb
);

    localparam logic [`VGA_FB_ADDRBITS-1:0] ROW_STRIDE = `VGA_CELLS_PER_ROW;

    logic [`VGA_FB_ADDRBITS-1:0] cell_row;
    logic [`VGA_FB_ADDRBITS-1:0] cell_col;
    logic                        visible_q;

    assign cell_row = {{(`VGA_FB_ADDRBITS-`VGA_ROWBITS+`VGA_CELL_SHIFT){1'b0}},
                       row[`VGA_ROWBITS-1:`VGA_CELL_SHIFT]};
    assign cell_col = {{(`VGA_FB_ADDRBITS-`VGA_COLBITS+`VGA_CELL_SHIFT){1'b0}},
                       col[`VGA_COLBITS-1:`VGA_CELL_SHIFT]};

    assign scan_req  = visible;                        // fetch every visible pixel.
    assign scan_addr = cell_row * ROW_STRIDE + cell_col;

    // one cycle of delay to match the RAM read latency.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            vga_hsync <= 1'b1;
            vga_vsync <= 1'b1;
            visible_q <= 1'b0;
        end else begin
            vga_hsync <= hsync;
            vga_vsync <= vsync;
            visible_q <= visible;
        end
    end

    assign vga_rgb = visible_q ? ram_rdata : '0;      // black in blanking.

endmodule

// File: fb_arbiter.sv
`timescale 1ns/1ps
`include "vga_settings.svh"

module fb_arbiter import vga_pkg::*; (
    input  logic                         scan_req,
    input  logic [`VGA_FB_ADDRBITS-1:0]  scan_addr,
    input  logic                         host_req,
    input  logic [`VGA_FB_ADDRBITS-1:0]  host_addr,
    input  logic [`VGA_RGBBITS-1:0]      host_wdata,
    output logic                         host_gnt,
    output fb_owner_e                    owner,
    output logic                         ram_we,
    output logic [`VGA_FB_ADDRBITS-1:0]  ram_addr,
    output logic [`VGA_RGBBITS-1:0]      ram_wdata
);

    // ============================================================
    // fixed priority, scanout first
    // ============================================================
    // the port idles on the host side when nobody asks.
    assign owner    = scan_req ? OWNER_SCAN : OWNER_HOST;
    assign host_gnt = host_req && (owner == OWNER_HOST);

    assign ram_we    = host_gnt;
    assign ram_addr  = (owner == OWNER_SCAN) ? scan_addr : host_addr;
    assign ram_wdata = host_wdata;                     // only used with ram_we.

endmodule

// File: fb_ram.sv
`timescale 1ns/1ps
`include "vga_settings.svh"

module fb_ram (
    input  logic                         clk,
    input  logic                         we,
    input  logic [`VGA_FB_ADDRBITS-1:0]  addr,
    input  logic [`VGA_RGBBITS-1:0]      wdata,
    output logic [`VGA_RGBBITS-1:0]      rdata
);

    logic [`VGA_RGBBITS-1:0] mem [`VGA_FB_DEPTH];

    // read returns the old word on a write cycle.
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];
    end

endmodule

// File: apb_fb_port.sv
`timescale 1ns/1ps
`include "vga_settings.svh"

module apb_fb_port import vga_pkg::*; (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic                         psel,
    input  logic                         penable,
    input  logic                         pwrite,
    input  logic [3:0]                   paddr,
    input  logic [31:0]                  pwdata,
    input  logic                         frame_start,
    input  logic                         host_gnt,
    output logic [31:0]                  prdata,
    output logic                         pready,
    output vga_mode_e                    mode,
    output logic                         host_req,
    output logic [`VGA_FB_ADDRBITS-1:0]  host_addr,
    output logic [`VGA_RGBBITS-1:0]      host_wdata
);

    localparam logic [1:0] REG_CTRL      = 2'd0;
    localparam logic [1:0] REG_CELL_ADDR = 2'd1;
    localparam logic [1:0] REG_CELL_DATA = 2'd2;
    localparam logic [1:0] REG_STATUS    = 2'd3;

    localparam logic [`VGA_FB_ADDRBITS-1:0] LAST_CELL = `VGA_FB_DEPTH - 1;

    logic [1:0]                   reg_sel;
    logic                         access;
    logic                         data_wr;
    logic [`VGA_FB_ADDRBITS-1:0]  cell_addr;
    logic [15:0]                  frame_cnt;

    assign reg_sel = paddr[3:2];
    assign access  = psel && penable;
    assign data_wr = access && pwrite && (reg_sel == REG_CELL_DATA);

    // a colour write waits for a free RAM cycle.
    assign host_req   = data_wr;
    assign host_addr  = cell_addr;
    assign host_wdata = pwdata[`VGA_RGBBITS-1:0];
    assign pready     = access && (!data_wr || host_gnt);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mode      <= MODE_640X480;
            cell_addr <= '0;
            frame_cnt <= '0;
        end else begin
            if (frame_start) begin
                frame_cnt <= frame_cnt + 1'b1;         // wraps.
            end
            if (access && pwrite) begin
                case (reg_sel)
                    REG_CTRL:      mode <= vga_mode_e'(pwdata[0]);
                    REG_CELL_ADDR: cell_addr <= pwdata[`VGA_FB_ADDRBITS-1:0];
                    REG_CELL_DATA: begin
                        if (host_gnt) begin
                            cell_addr <= (cell_addr == LAST_CELL) ? '0 : cell_addr + 1'b1;
                        end
                    end
                    default: ;                         // STATUS is read-only.
                endcase
            end
        end
    end

    always_comb begin
        prdata = '0;
        if (psel && !pwrite) begin
            case (reg_sel)
                REG_CTRL:      prdata = {31'd0, mode};
                REG_CELL_ADDR: prdata = {{(32-`VGA_FB_ADDRBITS){1'b0}}, cell_addr};
                REG_STATUS:    prdata = {16'd0, frame_cnt};
                default:       prdata = '0;            // CELL_DATA reads 0.
            endcase
        end
    end

endmodule

// File: vga_top.sv
`timescale 1ns/1ps
`include "vga_settings.svh"

module vga_top import vga_pkg::*; (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     psel,
    input  logic                     penable,
    input  logic                     pwrite,
    input  logic [3:0]               paddr,
    input  logic [31:0]              pwdata,
    output logic [31:0]              prdata,
    output logic                     pready,
    output logic                     pslverr,
    output logic                     vga_hsync,
    output logic                     vga_vsync,
    output logic [`VGA_RGBBITS-1:0]  vga_rgb
);

    vga_mode_e                    mode;
    fb_owner_e                    owner;                 // debug only.
    logic                         frame_start;
    logic                         host_req;
    logic                         host_gnt;
    logic [`VGA_FB_ADDRBITS-1:0]  host_addr;
    logic [`VGA_RGBBITS-1:0]      host_wdata;
    logic [`VGA_COLBITS-1:0]      col;
    logic [`VGA_ROWBITS-1:0]      row;
    logic                         hsync;
    logic                         vsync;
    logic                         visible;
    logic                         scan_req;
    logic [`VGA_FB_ADDRBITS-1:0]  scan_addr;
    logic                         ram_we;
    logic [`VGA_FB_ADDRBITS-1:0]  ram_addr;
    logic [`VGA_RGBBITS-1:0]      ram_wdata;
    logic [`VGA_RGBBITS-1:0]      ram_rdata;

    assign pslverr = 1'b0;

    apb_fb_port u_apb (
        .clk (clk), .arst_n (arst_n), .psel (psel), .penable (penable),
        .pwrite (pwrite), .paddr (paddr), .pwdata (pwdata),
        .frame_start (frame_start), .host_gnt (host_gnt), .prdata (prdata),
        .pready (pready), .mode (mode), .host_req (host_req),
        .host_addr (host_addr), .host_wdata (host_wdata)
    );

    vga_timing u_timing (
        .clk (clk), .arst_n (arst_n), .mode_req (mode), .col (col), .row (row),
        .hsync (hsync), .vsync (vsync), .visible (visible), .frame_start (frame_start)
    );

    vga_scanout u_scanout (
        .clk (clk), .arst_n (arst_n), .col (col), .row (row), .hsync (hsync),
        .vsync (vsync), .visible (visible), .ram_rdata (ram_rdata),
        .scan_req (scan_req), .scan_addr (scan_addr), .vga_hsync (vga_hsync),
        .vga_vsync (vga_vsync), .vga_rgb (vga_rgb)
    );

    fb_arbiter u_arbiter (
        .scan_req (scan_req), .scan_addr (scan_addr), .host_req (host_req),
        .host_addr (host_addr), .host_wdata (host_wdata), .host_gnt (host_gnt),
        .owner (owner), .ram_we (ram_we), .ram_addr (ram_addr), .ram_wdata (ram_wdata)
    );

    fb_ram u_ram (
        .clk (clk), .we (ram_we), .addr (ram_addr), .wdata (ram_wdata), .rdata (ram_rdata)
    );

endmodule

// File: tb_vga_top.sv
`timescale 1ns/1ps
`include "vga_settings.svh"

module tb_vga_top import vga_pkg::*; ();

    localparam int CLK_PERIOD  = 4;
    localparam int H_TOTAL     = 800;
    localparam int H_VISIBLE   = 640;
    localparam int WATCHDOG_NS = 8 * 525 * H_TOTAL * CLK_PERIOD + 100_000;
    localparam logic [3:0] ADDR_CTRL = 4'h0, ADDR_CELL_ADDR = 4'h4;
    localparam logic [3:0] ADDR_CELL_DATA = 4'h8, ADDR_STATUS = 4'hc;
    localparam int TAB_LEN = 8;

    logic clk, arst_n, psel, penable, pwrite, pready, pslverr, vga_hsync, vga_vsync;
    logic [3:0] paddr;
    logic [31:0] pwdata, prdata;
    logic [`VGA_RGBBITS-1:0] vga_rgb;
    logic [`VGA_RGBBITS-1:0] model [`VGA_FB_DEPTH];
    bit known [`VGA_FB_DEPTH];
    int tab_addr [TAB_LEN], tab_count [TAB_LEN];
    logic [`VGA_RGBBITS-1:0] tab_colour [TAB_LEN];
    int seed, errors, checks, pix_checks, cell_ptr, frames, vs_pulses, tcol, trow;
    bit synced, prev_vs;
    vga_mode_e cur_mode, pend_mode;

    vga_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("MISMATCH at %0t: %s expected %0h actual %0h", $time, name, exp, act);
        end
    endtask

    // setup on one falling edge, access on the next, pready sampled mid low phase.
    task automatic apb_access(input logic wr, input logic [3:0] addr, input logic [31:0] data,
                              output logic [31:0] rdata, output int waits);
        @(negedge clk);
        psel = 1'b1;
        penable = 1'b0;
        pwrite = wr;
        paddr = addr;
        pwdata = data;
        @(negedge clk);
        penable = 1'b1;
        waits = 0;
        #1;
        while (!pready) begin
            @(negedge clk);
            #1;
            waits++;
        end
        rdata = prdata;
        check_value("pslverr", 0, pslverr);
        @(negedge clk);
        psel = 1'b0;
        penable = 1'b0;
    endtask

    task automatic read_expect(input string name, input logic [3:0] addr, input logic [31:0] exp);
        logic [31:0] rdata;
        int waits;
        apb_access(1'b0, addr, '0, rdata, waits);
        check_value(name, exp, rdata);
    endtask

    task automatic set_cell_addr(input int addr);
        logic [31:0] rdata;
        int waits;
        apb_access(1'b1, ADDR_CELL_ADDR, addr, rdata, waits);
        cell_ptr = addr;
    endtask

    task automatic write_cell(input logic [`VGA_RGBBITS-1:0] colour, output int waits);
        logic [31:0] rdata;
        apb_access(1'b1, ADDR_CELL_DATA, {20'd0, colour}, rdata, waits);
        assert (waits <= H_VISIBLE) else begin
            errors++;
            $display("ERROR: write to cell %0d stalled for %0d cycles", cell_ptr, waits);
        end
        model[cell_ptr] = colour;
        known[cell_ptr] = 1'b1;
        cell_ptr = (cell_ptr + 1) % `VGA_FB_DEPTH;
    endtask

    task automatic wait_frames(input int n);
        int target;
        target = frames + n;
        while (frames < target) @(negedge clk);
    endtask

    function automatic logic vsync_level(vga_mode_e m, int r);
        if (m == MODE_640X480) return (r >= 490 && r <= 491) ? 1'b0 : 1'b1;
        return (r >= 401 && r <= 403) ? 1'b1 : 1'b0;
    endfunction

    // ============================================================
    // position tracker and screen checks
    // ============================================================
    always @(negedge clk) begin : screen_monitor
        int idx;
        if (arst_n && synced) begin
            tcol++;
            if (tcol == H_TOTAL) begin
                tcol = 0;
                trow++;
                if (trow == ((cur_mode == MODE_640X480) ? 525 : 449)) begin
                    trow = 0;
                    cur_mode = pend_mode;                 // mode latched at the frame wrap.
                    frames++;
                end
            end
            check_value("vga_hsync", (tcol >= 656 && tcol <= 751) ? 0 : 1, vga_hsync);
            check_value("vga_vsync", vsync_level(cur_mode, trow), vga_vsync);
            if (tcol < H_VISIBLE && trow < ((cur_mode == MODE_640X480) ? 480 : 400)) begin
                idx = (trow / 8) * `VGA_CELLS_PER_ROW + tcol / 8;
                if (known[idx]) begin
                    check_value("vga_rgb", model[idx], vga_rgb);
                    pix_checks++;
                end
            end else begin
                check_value("vga_rgb", 0, vga_rgb);       // blanking is black.
            end
            if (prev_vs != cur_mode && vga_vsync == cur_mode) vs_pulses++;
        end else if (arst_n && prev_vs && !vga_vsync) begin
            synced = 1'b1;                                // first vsync edge is row 490, col 0.
            tcol = 0;
            trow = 490;
        end
        prev_vs = vga_vsync;
    end

    // ============================================================
    // test sequence
    // ============================================================
    initial begin
        int waits;
        logic [31:0] rdata, status0;
        int pulses0;
        arst_n = 1'b0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        seed = 32'he9cf;
        prev_vs = 1'b1;
        cur_mode = MODE_640X480;
        pend_mode = MODE_640X480;
        tab_addr = '{4798, 0, 79, 4799, 3999, 0, 0, 0};
        tab_count = '{3, 1, 1, 1, 1, 1, 2, 1};
        tab_colour = '{12'h123, 12'hf00, 12'h0f0, 12'h00f, 12'hfff, 0, 0, 0};
        for (int i = 5; i < TAB_LEN; i++) begin
            tab_addr[i] = $unsigned($random(seed)) % `VGA_FB_DEPTH;
            tab_colour[i] = $random(seed);
        end
        repeat (16) @(negedge clk);
        check_value("vga_hsync", 1, vga_hsync);
        check_value("vga_vsync", 1, vga_vsync);
        check_value("vga_rgb", 0, vga_rgb);
        check_value("pready", 0, pready);
        arst_n = 1'b1;
        read_expect("CTRL", ADDR_CTRL, 0);
        read_expect("STATUS", ADDR_STATUS, 0);
        apb_access(1'b1, ADDR_CTRL, 0, rdata, waits);
        read_expect("CTRL", ADDR_CTRL, 0);
        set_cell_addr(1234);
        read_expect("CELL_ADDR", ADDR_CELL_ADDR, 1234);
        read_expect("CELL_DATA", ADDR_CELL_DATA, 0);
        for (int i = 0; i < TAB_LEN; i++) begin
            set_cell_addr(tab_addr[i]);
            for (int k = 0; k < tab_count[i]; k++) write_cell(tab_colour[i] + k, waits);
            read_expect("CELL_ADDR", ADDR_CELL_ADDR, (tab_addr[i] + tab_count[i]) % 4800);
        end
        wait_frames(2);
        // a write at row 16 of cell 165 has to wait for the end of the visible line.
        set_cell_addr(165);
        while (!(tcol == 10 && trow == 16)) @(negedge clk);
        write_cell(12'h5a5, waits);
        assert (waits > 0) else begin
            errors++;
            $display("ERROR: write in the visible area did not wait for scanout");
        end
        wait_frames(1);
        apb_access(1'b0, ADDR_STATUS, '0, status0, waits);
        pulses0 = vs_pulses;
        while (vs_pulses == pulses0) @(negedge clk);
        apb_access(1'b1, ADDR_CTRL, 1, rdata, waits);
        pend_mode = MODE_640X400;
        read_expect("CTRL", ADDR_CTRL, 1);
        wait_frames(3);
        read_expect("STATUS", ADDR_STATUS, (status0 + vs_pulses - pulses0) & 16'hffff);
        assert (pix_checks > 0) else begin
            errors++;
            $display("ERROR: no visible pixel of a written cell was checked");
        end
        $display("checks %0d, pixel checks %0d, errors %0d", checks, pix_checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("ERROR: watchdog expired, the test sequence did not finish in time");
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// File: files.f
+incdir+.
vga_pkg.sv
vga_mode_generator.sv
vga_timing.sv
vga_scanout.sv
fb_arbiter.sv
fb_ram.sv
apb_fb_port.sv
vga_top.sv
tb_vga_top.sv

// File: Bender.yml
package:
  name: vga_fb

export_include_dirs:
  - .

sources:
  - vga_pkg.sv
  - vga_mode_generator.sv
  - vga_timing.sv
  - vga_scanout.sv
  - fb_arbiter.sv
  - fb_ram.sv
  - apb_fb_port.sv
  - vga_top.sv
  - target: test
    files:
      - tb_vga_top.sv
